// File: sap_cpu.f
hdl/sap_pkg.sv
hdl/sap_bus_if.sv
hdl/bus_arbiter.sv
hdl/program_counter.sv
hdl/memory_unit.sv
hdl/alu_unit.sv
hdl/io_port.sv
hdl/control_sequencer.sv
hdl/sap_cpu_top.sv
+incdir+tb
tb/tb_sap_cpu.sv

// File: tb/sap_cpu_model.svh
// Behavioral reference of the accumulator CPU, included inside the testbench module
// Runs a 16-byte image one instruction at a time and reports OUT values, flags and halt
`ifndef sap_cpu_model_svh
`define sap_cpu_model_svh

function automatic void run_model(
    input  logic [7:0] image [mem_depth],
    output logic [7:0] outs [step_limit],
    output int         n_outs,
    output logic       carry_f,
    output logic       zero_f,
    output bit         stops
);
    logic [3:0] pc;
    logic [7:0] acc;
    logic [7:0] opnd;
    logic [8:0] sum;
    instr_t     ins;
    int         step;

    pc      = 4'h0;
    acc     = 8'h00;   // Reset state of the accumulator and flags
    carry_f = 1'b0;
    zero_f  = 1'b0;
    n_outs  = 0;
    stops   = 1'b0;
    step    = 0;
    for (int k = 0; k < step_limit; k++)
        outs[k] = 8'h00;

    while (!stops && step < step_limit) begin
        ins.raw = image[pc];
        opnd    = image[ins.f.operand];   // Memory operand, RAM is never written
        pc      = pc + 4'h1;              // Wraps after 15
        step++;
        case (ins.f.opcode)
            op_lda: acc = opnd;
            op_add: begin
                sum     = {1'b0, acc} + {1'b0, opnd};
                acc     = sum[7:0];
                carry_f = sum[8];
                zero_f  = (acc == 8'h00);
            end
            op_sub: begin
                carry_f = (acc >= opnd);   // Carry set means no borrow
                acc     = acc - opnd;
                zero_f  = (acc == 8'h00);
            end
            op_jmp: pc = ins.f.operand;
            op_jc:  if (carry_f) pc = ins.f.operand;
            op_jz:  if (zero_f) pc = ins.f.operand;
            op_out: begin
                outs[n_outs] = acc;
                n_outs++;
            end
            op_hlt: stops = 1'b1;
            default: ;                     // No-operation
        endcase
    end
endfunction

`endif

// File: tb/tb_sap_cpu.sv
// Testbench for the accumulator CPU
// Loads program images through the loader strobes, runs them to HLT and compares
// the OUT values and final flags with the behavioral model
`timescale 1ns/1ps

module tb_sap_cpu import sap_pkg::*; ();

    localparam int step_limit = 64;   // Instructions the model may run

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic       programming;
    logic [7:0] uo_out;
    logic       out_valid;
    logic       ready_for_ui;
    logic       done_load;
    logic       halted;

    logic [7:0] img [mem_depth];        // Image for the next run
    logic [7:0] exp_outs [step_limit];
    int         exp_n;
    logic       exp_c;
    logic       exp_z;
    bit         exp_halt;
    logic [7:0] got_q [$];              // uo_out seen at each out_valid
    string      test_name;
    int         test_errs;
    int         err_cnt;
    int         tests_run;
    int         tests_failed;
    bit         timed_out;
    bit         check_done;
    event       check_req;

    `include "sap_cpu_model.svh"

    sap_cpu_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ui_in        (ui_in),
        .programming  (programming),
        .uo_out       (uo_out),
        .out_valid    (out_valid),
        .ready_for_ui (ready_for_ui),
        .done_load    (done_load),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // Output monitor, outputs settle well before the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (out_valid)
                got_q.push_back(uo_out);
        end
    end

    // Compares the recorded run against the model on request
    initial begin
        forever begin
            @(check_req);
            assert (got_q.size() == exp_n) else begin
                $display("[ERROR] %s: OUT count expected %0d actual %0d",
                         test_name, exp_n, got_q.size());
                test_errs++;
            end
            for (int i = 0; i < exp_n && i < got_q.size(); i++) begin
                assert (got_q[i] == exp_outs[i]) else begin
                    $display("[ERROR] %s: OUT %0d expected %02h actual %02h",
                             test_name, i, exp_outs[i], got_q[i]);
                    test_errs++;
                end
            end
            assert (uut.carry == exp_c && uut.zero == exp_z) else begin
                $display("[ERROR] %s: flags c/z expected %0b%0b actual %0b%0b",
                         test_name, exp_c, exp_z, uut.carry, uut.zero);
                test_errs++;
            end
            check_done = 1'b1;
        end
    end

    task automatic note_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        timed_out = 1'b1;
        test_errs++;
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        programming = 1'b0;
        ui_in       = 8'h00;
        got_q.delete();          // out_valid is low throughout reset
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Loader protocol, cycle A starts as soon as programming rises
    task automatic load_image();
        int n;
        programming = 1'b1;
        ui_in       = img[0];
        for (int i = 0; i < mem_depth; i++) begin
            if (i > 0) begin
                n = 0;
                while (!ready_for_ui && n < 8) begin
                    @(negedge clk);
                    n++;
                end
                if (!ready_for_ui) begin
                    note_timeout("ready_for_ui while loading");
                    return;
                end
                ui_in = img[i];                      // Held through cycles A and B
            end
            @(negedge clk);                          // Cycle B
            assert (!ready_for_ui) else begin
                $display("%s: ready_for_ui high in loader cycle B", test_name);
                test_errs++;
            end
            @(negedge clk);                          // Byte i now in RAM
            assert (done_load == (i == mem_depth - 1)) else begin
                $display("[ERROR] %s: done_load after byte %0d expected %0b actual %0b",
                         test_name, i, i == mem_depth - 1, done_load);
                test_errs++;
            end
        end
        programming = 1'b0;
        ui_in       = 8'h00;
    endtask

    // Reset, load img, run to HLT, then watch the halted CPU for quiet cycles
    task automatic run_image(input int quiet);
        int n;
        if (timed_out)
            return;
        apply_reset();
        run_model(img, exp_outs, exp_n, exp_c, exp_z, exp_halt);
        load_image();
        if (timed_out)
            return;
        n = 0;
        while (!halted && n < step_limit * t_states + 20) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            note_timeout("halted after the program started");
            return;
        end
        repeat (quiet) begin
            @(negedge clk);
            assert (halted && !out_valid) else begin
                $display("%s: halted dropped or out_valid pulsed after HLT", test_name);
                test_errs++;
            end
        end
        check_done = 1'b0;
        -> check_req;
        n = 0;
        while (!check_done && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!check_done)
            note_timeout("the comparison");
    endtask

    // Random bytes with HLT forced at 15, retried until the model halts
    task automatic make_random_image();
        int tries;
        tries = 0;
        do begin
            foreach (img[i])
                img[i] = 8'($urandom);
            img[mem_depth - 1] = {op_hlt, 4'h0};
            run_model(img, exp_outs, exp_n, exp_c, exp_z, exp_halt);
            tries++;
        end while (!exp_halt && tries < 50);
        if (!exp_halt)
            img[0] = {op_hlt, 4'h0};
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        err_cnt += test_errs;
        $display("test %-8s %s, %0d errors", test_name,
                 (test_errs == 0) ? "ok" : "FAILED", test_errs);
        test_errs = 0;
    endtask

    task automatic test_reset();
        test_name = "reset";
        apply_reset();
        repeat (20) begin
            @(negedge clk);
            assert (uo_out == 8'h00 && !out_valid && !ready_for_ui && !done_load
                    && !halted && uut.bus_if.bus == 8'h00) else begin
                $display("%s: outputs or bus not idle after reset", test_name);
                test_errs++;
            end
        end
        finish_test();
    endtask

    task automatic test_load();
        test_name = "load";
        foreach (img[i])
            img[i] = 8'($urandom);
        img[0] = 8'h0E;          // LDA 14
        img[1] = 8'hE0;          // OUT
        img[2] = 8'hF0;          // HLT
        run_image(10);
        finish_test();
    endtask

    task automatic test_arith();
        test_name = "arith";
        for (int k = 0; k < 4; k++) begin
            // LDA 13, ADD 14, OUT, SUB 15, OUT, SUB 14, OUT, HLT
            img = '{8'h0D, 8'h1E, 8'hE0, 8'h2F, 8'hE0, 8'h2E, 8'hE0, 8'hF0,
                    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
            img[13] = 8'($urandom) | 8'h80;   // Makes ADD wraparound likely
            img[14] = 8'($urandom);
            img[15] = 8'($urandom);
            if (k == 0) begin                 // ADD carries, then SUB borrows
                img[14] = img[14] | 8'h80;
                img[15] = 8'hFF;
            end
            run_image(10);
        end
        finish_test();
    endtask

    task automatic test_branch();
        test_name = "branch";
        for (int k = 0; k < 4; k++) begin
            // LDA 13, ADD 14, JC 6, OUT, SUB 15, JZ 8, OUT, JMP 9, LDA 14, OUT, HLT
            img = '{8'h0D, 8'h1E, 8'h76, 8'hE0, 8'h2F, 8'h88, 8'hE0, 8'h69,
                    8'h0E, 8'hE0, 8'hF0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
            img[13] = 8'($urandom);
            img[14] = 8'($urandom);
            img[15] = 8'($urandom);
            if (k == 0) begin                 // Carry out, JC taken
                img[13] = img[13] | 8'h80;
                img[14] = img[14] | 8'h80;
            end
            if (k == 1) begin                 // No carry, SUB gives zero so JZ taken
                img[13] = img[13] & 8'h7F;
                img[14] = img[14] & 8'h7F;
                img[15] = img[13] + img[14];
            end
            if (k == 2) begin                 // No carry, SUB non-zero so both fall through
                img[13] = img[13] & 8'h7F;
                img[14] = img[14] & 8'h7F;
                img[15] = img[13] + img[14] + 8'h01;
            end
            run_image(10);
        end
        finish_test();
    endtask

    task automatic test_halt();
        test_name = "halt";
        // LDA 15, OUT, HLT, then outputs that must never appear
        img = '{8'h0F, 8'hE0, 8'hF0, 8'hE0, 8'h0E, 8'hE0, 8'hE0, 8'h00,
                8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        img[14] = 8'($urandom);
        img[15] = 8'($urandom);
        run_image(60);
        make_random_image();                  // Second program after a fresh reset
        run_image(10);
        finish_test();
    endtask

    task automatic test_random();
        test_name = "random";
        for (int k = 0; k < 5; k++) begin
            make_random_image();
            run_image(10);
        end
        finish_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        programming  = 1'b0;
        ui_in        = 8'h00;
        test_errs    = 0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        check_done   = 1'b0;
        void'($urandom(32'hc0d9_f69f));

        test_reset();
        if (!timed_out) test_load();
        if (!timed_out) test_arith();
        if (!timed_out) test_branch();
        if (!timed_out) test_halt();
        if (!timed_out) test_random();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (timed_out || err_cnt != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

// File: hdl/sap_cpu_top.sv
// Top level of the accumulator CPU
// Wires the bus peers, arbiter and sequencer to the external pins
`timescale 1ns/1ps

module sap_cpu_top import sap_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] ui_in,         // Program bytes and input data
    input  logic       programming,   // High while loading a program
    output logic [7:0] uo_out,
    output logic       out_valid,
    output logic       ready_for_ui,
    output logic       done_load,
    output logic       halted
);

    logic [ctrl_w-1:0] ctrl;          // Control word from the sequencer
    logic              carry;
    logic              zero;

    sap_bus_if bus_if (.clk(clk));

    bus_arbiter arb (.b(bus_if.arbiter));

    program_counter pc (
        .clk   (clk),
        .rst_n (rst_n),
        .cp    (ctrl[c_cp]),
        .lp    (ctrl[c_lp]),
        .ep    (ctrl[c_ep]),
        .b     (bus_if.pc)
    );

    memory_unit mem (
        .clk   (clk),
        .rst_n (rst_n),
        .lma   (ctrl[c_lma]),
        .ce    (ctrl[c_ce]),
        .write (ctrl[c_lr]),
        .b     (bus_if.mem)
    );

    alu_unit alu (
        .clk   (clk),
        .rst_n (rst_n),
        .la    (ctrl[c_la]),
        .lb    (ctrl[c_lb]),
        .ea    (ctrl[c_ea]),
        .eu    (ctrl[c_eu]),
        .sub   (ctrl[c_sub]),
        .carry (carry),
        .zero  (zero),
        .b     (bus_if.alu)
    );

    io_port io (
        .clk       (clk),
        .rst_n     (rst_n),
        .ein       (ctrl[c_ein]),
        .lo        (ctrl[c_lo]),
        .ui_in     (ui_in),
        .uo_out    (uo_out),
        .out_valid (out_valid),
        .b         (bus_if.io)
    );

    control_sequencer seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .programming  (programming),
        .carry        (carry),
        .zero         (zero),
        .ready_for_ui (ready_for_ui),
        .done_load    (done_load),
        .halted       (halted),
        .ctrl         (ctrl),
        .b            (bus_if.ir)
    );

endmodule

// File: hdl/control_sequencer.sv
// Control unit of the CPU
// Loads the program from the input port while programming is high, then runs
// the six-state fetch/execute ring and decodes it into the control word
`timescale 1ns/1ps

module control_sequencer import sap_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              programming,   // Loader request from outside
    input  logic              carry,         // ALU flags for JC and JZ
    input  logic              zero,
    output logic              ready_for_ui,  // Loader cycle A, byte wanted soon
    output logic              done_load,
    output logic              halted,
    output logic [ctrl_w-1:0] ctrl,
    sap_bus_if.ir             b
);

    logic [3:0]          load_cnt;   // Bytes written so far
    logic                phase_b;    // Loader cycle B when set
    logic                run;        // Execution enabled
    logic [t_states-1:0] ring;       // One-hot T-state, bit 0 is T1
    instr_t              ir;
    logic                loading;
    logic                start;
    logic                hlt_t3;

    assign loading      = programming && !done_load && !halted;
    assign start        = !programming && done_load;
    assign ready_for_ui = loading && !phase_b;
    assign hlt_t3       = run && ring[2] && (ir.f.opcode == op_hlt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt  <= 4'h0;
            phase_b   <= 1'b0;
            done_load <= 1'b0;
            run       <= 1'b0;
            ring      <= t_states'(1);
            halted    <= 1'b0;
            ir        <= '0;
        end else begin
            if (loading) begin
                phase_b <= !phase_b;
                if (phase_b) begin                       // Byte written this cycle
                    load_cnt <= load_cnt + 4'h1;
                    if (load_cnt == 4'(mem_depth - 1))
                        done_load <= 1'b1;
                end
            end

            if (run && !halted && !hlt_t3)
                ring <= {ring[t_states-2:0], ring[t_states-1]};   // Rotate
            if (hlt_t3)
                halted <= 1'b1;                          // Ring stays on T3

            if (start) begin
                done_load <= 1'b0;
                load_cnt  <= 4'h0;
                phase_b   <= 1'b0;
                run       <= 1'b1;
                ring      <= t_states'(1);               // Begin at T1
            end else if (programming) begin
                run <= 1'b0;                             // Reload stops execution
            end

            if (ctrl[c_li])
                ir.raw <= b.bus;
        end
    end

    // Operand nibble for LDA/ADD/SUB addresses and jump targets
    assign b.ir_en  = ctrl[c_ei];
    assign b.ir_val = {4'h0, ir.f.operand};

    always_comb begin
        ctrl = '0;
        if (loading) begin
            if (!phase_b) begin
                ctrl[c_ep]  = 1'b1;                      // A: PC to MAR
                ctrl[c_lma] = 1'b1;
            end else begin
                ctrl[c_ein] = 1'b1;                      // B: input byte to RAM
                ctrl[c_lr]  = 1'b1;
                ctrl[c_cp]  = 1'b1;
            end
        end else if (start) begin
            ctrl[c_lp] = 1'b1;                           // Bus idle, so PC clears
        end else if (run) begin
            if (ring[0]) begin                           // T1 fetch address
                ctrl[c_ep]  = 1'b1;
                ctrl[c_lma] = 1'b1;
            end
            if (ring[1]) begin                           // T2 fetch instruction
                ctrl[c_ce] = 1'b1;
                ctrl[c_li] = 1'b1;
                ctrl[c_cp] = 1'b1;
            end
            if (ring[2]) begin
                case (ir.f.opcode)
                    op_lda, op_add, op_sub: begin
                        ctrl[c_ei]  = 1'b1;              // Operand address
                        ctrl[c_lma] = 1'b1;
                    end
                    op_jmp: begin
                        ctrl[c_ei] = 1'b1;
                        ctrl[c_lp] = 1'b1;
                    end
                    op_jc: begin
                        ctrl[c_ei] = carry;
                        ctrl[c_lp] = carry;
                    end
                    op_jz: begin
                        ctrl[c_ei] = zero;
                        ctrl[c_lp] = zero;
                    end
                    op_out: begin
                        ctrl[c_ea] = 1'b1;
                        ctrl[c_lo] = 1'b1;
                    end
                    default: ctrl = '0;                  // HLT and no-ops
                endcase
            end
            if (ring[3]) begin                           // T4 memory operand
                if (ir.f.opcode == op_lda) begin
                    ctrl[c_ce] = 1'b1;
                    ctrl[c_la] = 1'b1;
                end else if (ir.f.opcode == op_add || ir.f.opcode == op_sub) begin
                    ctrl[c_ce] = 1'b1;
                    ctrl[c_lb] = 1'b1;
                end
            end
            if (ring[4] && (ir.f.opcode == op_add || ir.f.opcode == op_sub)) begin
                ctrl[c_eu]  = 1'b1;                      // T5 result back to A
                ctrl[c_la]  = 1'b1;
                ctrl[c_sub] = (ir.f.opcode == op_sub);
            end
        end
    end

    a_ring_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(ring)
    ) else $error("control_sequencer: T-state ring not one-hot");

    // Halt must silence every peer across all later cycles
    a_halt_quiet : assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |-> (ctrl == '0)
    ) else $error("control_sequencer: control bit active while halted");

endmodule

// File: hdl/io_port.sv
// Input byte driver and output register
// out_valid pulses for one clock after each output load
`timescale 1ns/1ps

module io_port (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ein,        // ui_in onto bus
    input  logic       lo,         // Output register load
    input  logic [7:0] ui_in,
    output logic [7:0] uo_out,
    output logic       out_valid,
    sap_bus_if.io      b
);

    assign b.in_en  = ein;
    assign b.in_val = ui_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uo_out    <= 8'h00;
            out_valid <= 1'b0;
        end else begin
            out_valid <= lo;           // lo lasts one T-state, so one pulse
            if (lo)
                uo_out <= b.bus;       // Accumulator value from OUT
        end
    end

endmodule

// File: hdl/alu_unit.sv
// Accumulator, B register and adder/subtractor
// Flags register only when the ALU result is written back into A
`timescale 1ns/1ps

module alu_unit (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    la,      // A load from bus
    input  logic    lb,      // B load from bus
    input  logic    ea,      // A onto bus
    input  logic    eu,      // Result onto bus
    input  logic    sub,     // Subtract when high
    output logic    carry,
    output logic    zero,
    sap_bus_if.alu  b
);

    logic [7:0] acc;
    logic [7:0] breg;
    logic [7:0] b_op;
    logic [8:0] sum;

    // Subtract as A + ~B + 1, carry means no borrow
    assign b_op = sub ? ~breg : breg;
    assign sum  = {1'b0, acc} + {1'b0, b_op} + 9'(sub);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc   <= 8'h00;
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (la) begin
            acc <= b.bus;
            if (eu) begin                 // Write-back of an ALU result
                carry <= sum[8];
                zero  <= (sum[7:0] == 8'h00);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            breg <= 8'h00;
        else if (lb)
            breg <= b.bus;
    end

    assign b.acc_en  = ea;
    assign b.acc_val = acc;
    assign b.alu_en  = eu;
    assign b.alu_val = sum[7:0];     // Wraps mod 256

endmodule

// File: hdl/memory_unit.sv
// Memory address register and 16-byte RAM
// Write from the bus on write, read onto the bus on ce, both at the MAR address
`timescale 1ns/1ps

module memory_unit import sap_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    lma,     // MAR load
    input  logic    ce,      // RAM onto bus
    input  logic    write,   // RAM write from bus
    sap_bus_if.mem  b
);

    logic [3:0] mar;
    instr_t     ram [mem_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= 4'h0;
        end else if (lma) begin
            mar <= b.bus[3:0];           // Address from PC or operand
        end
    end

    // Contents survive reset, only the loader writes them
    always_ff @(posedge clk) begin
        if (write)
            ram[mar].raw <= b.bus;
    end

    // Combinational read from the MAR
    assign b.mem_en  = ce;
    assign b.mem_val = ram[mar].raw;

    a_rw_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(write && ce)
    ) else $error("memory_unit: RAM read and write in the same cycle");

endmodule

// File: hdl/program_counter.sv
// 4-bit program counter
// Counts on cp, loads the low bus nibble on lp, drives the bus on ep
`timescale 1ns/1ps

module program_counter (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cp,     // Count up
    input  logic   lp,     // Jump load
    input  logic   ep,     // Output enable
    sap_bus_if.pc  b
);

    logic [3:0] pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= 4'h0;
        end else if (lp) begin
            pc <= b.bus[3:0];          // Jump target, or zero from an idle bus
        end else if (cp) begin
            pc <= pc + 4'h1;           // Wraps after address 15
        end
    end

    assign b.pc_en  = ep;
    assign b.pc_val = {4'h0, pc};      // Upper nibble unused

    // Decode never counts and loads in the same T-state
    a_cp_lp_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cp && lp)
    ) else $error("program_counter: cp and lp high together");

endmodule

// File: hdl/bus_arbiter.sv
// Resolves the single enabled driver onto the shared bus
// Purely combinational, the bus reads zero when nobody drives it
`timescale 1ns/1ps

module bus_arbiter (
    sap_bus_if.arbiter b
);

    // AND-OR mux, at most one term is non-zero
    assign b.bus = ({8{b.pc_en}}  & b.pc_val)
                 | ({8{b.mem_en}} & b.mem_val)
                 | ({8{b.ir_en}}  & b.ir_val)
                 | ({8{b.alu_en}} & b.alu_val)
                 | ({8{b.acc_en}} & b.acc_val)
                 | ({8{b.in_en}}  & b.in_val);

    // Two drivers at once would OR their values together silently
    a_one_driver : assert property (
        @(posedge b.clk)
        $onehot0({b.pc_en, b.mem_en, b.ir_en, b.alu_en, b.acc_en, b.in_en})
    ) else $error("bus_arbiter: more than one bus driver enabled");

endmodule

// File: hdl/sap_bus_if.sv
// Shared 8-bit data bus of the CPU
// Each peer drives its own value and enable, the arbiter resolves them onto bus
`timescale 1ns/1ps

interface sap_bus_if (
    input logic clk   // Only used for checks on the resolved bus
);
    logic       pc_en;
    logic [7:0] pc_val;   // PC in the low nibble
    logic       mem_en;
    logic [7:0] mem_val;
    logic       ir_en;
    logic [7:0] ir_val;   // Operand in the low nibble
    logic       alu_en;
    logic [7:0] alu_val;
    logic       acc_en;
    logic [7:0] acc_val;
    logic       in_en;
    logic [7:0] in_val;
    logic [7:0] bus;      // Resolved value

    modport pc  (output pc_en, pc_val, input bus);
    modport mem (output mem_en, mem_val, input bus);
    modport ir  (output ir_en, ir_val, input bus);
    modport alu (output alu_en, alu_val, acc_en, acc_val, input bus);
    modport io  (output in_en, in_val, input bus);

    modport arbiter (
        input  clk,
        input  pc_en, pc_val, mem_en, mem_val, ir_en, ir_val,
        input  alu_en, alu_val, acc_en, acc_val, in_en, in_val,
        output bus
    );

endinterface

// File: hdl/sap_pkg.sv
// Shared constants and types for the SAP-style accumulator CPU
// Import with a wildcard in any module that decodes opcodes or the control word
package sap_pkg;

    // Opcodes, upper nibble of the instruction byte
    localparam logic [3:0] op_lda = 4'd0;   // A <= mem[operand]
    localparam logic [3:0] op_add = 4'd1;   // A <= A + mem[operand], flags
    localparam logic [3:0] op_sub = 4'd2;   // A <= A - mem[operand], flags
    localparam logic [3:0] op_jmp = 4'd6;   // PC <= operand
    localparam logic [3:0] op_jc  = 4'd7;   // Jump on carry
    localparam logic [3:0] op_jz  = 4'd8;   // Jump on zero
    localparam logic [3:0] op_out = 4'd14;  // Output register <= A
    localparam logic [3:0] op_hlt = 4'd15;  // Stop until reset

    // Control word, all bits active high
    localparam int ctrl_w = 15;

    localparam int c_cp  = 14;  // PC count
    localparam int c_ep  = 13;  // PC onto bus
    localparam int c_lp  = 12;  // PC load from bus
    localparam int c_lma = 11;  // MAR load
    localparam int c_ein = 10;  // Input port onto bus
    localparam int c_ce  = 9;   // RAM onto bus
    localparam int c_lr  = 8;   // RAM write from bus
    localparam int c_li  = 7;   // Instruction register load
    localparam int c_ei  = 6;   // Operand nibble onto bus
    localparam int c_la  = 5;   // Accumulator load
    localparam int c_ea  = 4;   // Accumulator onto bus
    localparam int c_sub = 3;   // ALU subtract select
    localparam int c_eu  = 2;   // ALU result onto bus
    localparam int c_lb  = 1;   // B register load
    localparam int c_lo  = 0;   // Output register load

    localparam int t_states  = 6;   // Clocks per instruction
    localparam int mem_depth = 16;  // Addressed by a 4-bit operand

    // One instruction byte, seen either as fields or as plain data
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [3:0] operand;
        } f;
        logic [7:0] raw;
    } instr_t;

endpackage
